//--- build.f
hdl/dice_pkg.sv
hdl/key_pulse.sv
hdl/roll_sequencer.sv
hdl/lcg_core.sv
hdl/save_slot.sv
hdl/seg7_out.sv
hdl/dice_top.sv
sim/tb_dice.sv

//--- hdl/dice_pkg.sv
package dice_pkg;

	// phases of one roll, also the code shown on the board
	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_FAST   = 3'd1,
		ST_MEDIUM = 3'd2,
		ST_SLOW   = 3'd3,
		ST_STOP   = 3'd4,
		ST_FINAL  = 3'd5
	} roll_state_t;

	// one dice value, a single hex digit
	localparam int VAL_W = 4;

	// saved output carries a blank flag above the value
	localparam int SAVED_W = VAL_W + 1;

	// shown outside idle and when the slot holds nothing
	localparam logic [SAVED_W-1:0] SAVED_BLANK = '1;

	// segments a to g
	localparam int SEG_W = 7;

endpackage

//--- hdl/dice_top.sv
module dice_top #(
	parameter int unsigned FAST_TICKS   = 100_000_000,
	parameter int unsigned MEDIUM_TICKS = 100_000_000,
	parameter int unsigned SLOW_TICKS   = 100_000_000,
	parameter int unsigned FAST_STEP    = 600_000,
	parameter int unsigned MEDIUM_STEP  = 2_000_000,
	parameter int unsigned SLOW_STEP    = 8_000_000,
	parameter int unsigned LCG_A        = 11,
	parameter int unsigned LCG_B        = 29,
	parameter int unsigned LCG_SEED     = 9
) (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_start,
	input  logic                         i_stop,
	input  logic                         i_save,
	output logic [dice_pkg::VAL_W-1:0]   o_random_out,
	output logic [dice_pkg::SAVED_W-1:0] o_saved,
	output dice_pkg::roll_state_t        o_state,
	output logic [dice_pkg::SEG_W-1:0]   o_seg
);

	import dice_pkg::*;

	logic start_pulse;
	logic stop_pulse;
	logic save_pulse;
	roll_state_t state;
	logic seed_load;
	logic [VAL_W-1:0] seed_val;
	logic step;
	logic recall_load;
	logic [VAL_W-1:0] recall_val;
	logic [VAL_W-1:0] value;
	logic [SAVED_W-1:0] saved;

	key_pulse key_pulse_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_start),
		.i_stop        (i_stop),
		.i_save        (i_save),
		.o_start_pulse (start_pulse),
		.o_stop_pulse  (stop_pulse),
		.o_save_pulse  (save_pulse)
	);

	roll_sequencer #(
		.FAST_TICKS   (FAST_TICKS),
		.MEDIUM_TICKS (MEDIUM_TICKS),
		.SLOW_TICKS   (SLOW_TICKS),
		.FAST_STEP    (FAST_STEP),
		.MEDIUM_STEP  (MEDIUM_STEP),
		.SLOW_STEP    (SLOW_STEP)
	) roll_sequencer_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start_pulse (start_pulse),
		.i_stop_pulse  (stop_pulse),
		.o_state       (state),
		.o_seed_load   (seed_load),
		.o_seed_val    (seed_val),
		.o_step        (step)
	);

	lcg_core #(
		.LCG_A    (LCG_A),
		.LCG_B    (LCG_B),
		.LCG_SEED (LCG_SEED)
	) lcg_core_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_seed_load   (seed_load),
		.i_seed_val    (seed_val),
		.i_recall_load (recall_load),
		.i_recall_val  (recall_val),
		.i_step        (step),
		.o_value       (value)
	);

	save_slot save_slot_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_state       (state),
		.i_save_pulse  (save_pulse),
		.i_value       (value),
		.o_saved       (saved),
		.o_recall_load (recall_load),
		.o_recall_val  (recall_val)
	);

	seg7_out seg7_out_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_value      (value),
		.i_saved      (saved),
		.i_state      (state),
		.o_random_out (o_random_out),
		.o_saved_out  (o_saved),
		.o_state_out  (o_state),
		.o_seg        (o_seg)
	);

endmodule

//--- hdl/key_pulse.sv
module key_pulse (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_stop,
	input  logic i_save,
	output logic o_start_pulse,
	output logic o_stop_pulse,
	output logic o_save_pulse
);

	localparam int N_KEYS = 3;

	logic [N_KEYS-1:0] keys_raw;
	logic [N_KEYS-1:0] sync_q1;
	logic [N_KEYS-1:0] sync_q2;
	logic [N_KEYS-1:0] delay_q;
	logic [N_KEYS-1:0] rise;

	// bit order start, stop, save
	assign keys_raw = {i_save, i_stop, i_start};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			delay_q <= '0;
		end else begin
			sync_q1 <= keys_raw;
			sync_q2 <= sync_q1;
			delay_q <= sync_q2;
		end
	end

	// high for the first synchronized cycle of a press
	assign rise = sync_q2 & ~delay_q;

	assign o_start_pulse = rise[0];
	assign o_stop_pulse  = rise[1];
	assign o_save_pulse  = rise[2];

endmodule

//--- hdl/lcg_core.sv
module lcg_core #(
	parameter int unsigned LCG_A    = 11,
	parameter int unsigned LCG_B    = 29,
	parameter int unsigned LCG_SEED = 9
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_seed_load,
	input  logic [dice_pkg::VAL_W-1:0] i_seed_val,
	input  logic                       i_recall_load,
	input  logic [dice_pkg::VAL_W-1:0] i_recall_val,
	input  logic                       i_step,
	output logic [dice_pkg::VAL_W-1:0] o_value
);

	import dice_pkg::*;

	localparam int unsigned LCG_M = 2 ** VAL_W;

	logic [VAL_W-1:0] value_nxt;

	// x' = (a*x + b) mod 16
	always_comb begin
		value_nxt = VAL_W'((LCG_A * o_value + LCG_B) % LCG_M);
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_value <= VAL_W'(LCG_SEED);
		end else if (i_seed_load) begin
			o_value <= i_seed_val;
		end else if (i_recall_load) begin
			o_value <= i_recall_val;
		end else if (i_step) begin
			o_value <= value_nxt;
		end
	end

endmodule

//--- hdl/roll_sequencer.sv
module roll_sequencer #(
	parameter int unsigned FAST_TICKS   = 100_000_000,
	parameter int unsigned MEDIUM_TICKS = 100_000_000,
	parameter int unsigned SLOW_TICKS   = 100_000_000,
	parameter int unsigned FAST_STEP    = 600_000,
	parameter int unsigned MEDIUM_STEP  = 2_000_000,
	parameter int unsigned SLOW_STEP    = 8_000_000
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_start_pulse,
	input  logic                       i_stop_pulse,
	output dice_pkg::roll_state_t      o_state,
	output logic                       o_seed_load,
	output logic [dice_pkg::VAL_W-1:0] o_seed_val,
	output logic                       o_step
);

	import dice_pkg::*;

	localparam int unsigned MAX_TICKS_FM = (FAST_TICKS > MEDIUM_TICKS) ? FAST_TICKS : MEDIUM_TICKS;
	localparam int unsigned MAX_TICKS = (MAX_TICKS_FM > SLOW_TICKS) ? MAX_TICKS_FM : SLOW_TICKS;
	localparam int unsigned MAX_STEP_FM = (FAST_STEP > MEDIUM_STEP) ? FAST_STEP : MEDIUM_STEP;
	localparam int unsigned MAX_STEP = (MAX_STEP_FM > SLOW_STEP) ? MAX_STEP_FM : SLOW_STEP;
	localparam int TIMER_W = $clog2(MAX_TICKS + 1);
	localparam int STEP_W = $clog2(MAX_STEP + 1);

	roll_state_t state;
	roll_state_t state_nxt;
	roll_state_t last_phase;
	roll_state_t last_phase_nxt;
	logic [VAL_W-1:0] seed_cnt;
	logic [VAL_W-1:0] seed_cnt_nxt;
	logic [TIMER_W-1:0] timer;
	logic [TIMER_W-1:0] timer_nxt;
	logic [STEP_W-1:0] step_cnt;
	logic [STEP_W-1:0] step_cnt_nxt;
	logic [TIMER_W-1:0] phase_ticks;
	logic [STEP_W-1:0] phase_step;
	roll_state_t phase_next;
	logic seed_load_nxt;
	logic step_nxt;

	// duration, step interval and successor of the running phase
	always_comb begin
		case (state)
			ST_MEDIUM: begin
				phase_ticks = TIMER_W'(MEDIUM_TICKS);
				phase_step  = STEP_W'(MEDIUM_STEP);
				phase_next  = ST_SLOW;
			end
			ST_SLOW: begin
				phase_ticks = TIMER_W'(SLOW_TICKS);
				phase_step  = STEP_W'(SLOW_STEP);
				phase_next  = ST_FINAL;
			end
			default: begin
				phase_ticks = TIMER_W'(FAST_TICKS);
				phase_step  = STEP_W'(FAST_STEP);
				phase_next  = ST_MEDIUM;
			end
		endcase
	end

	always_comb begin
		state_nxt      = state;
		last_phase_nxt = last_phase;
		seed_cnt_nxt   = seed_cnt;
		timer_nxt      = timer;
		step_cnt_nxt   = step_cnt;
		seed_load_nxt  = 1'b0;
		step_nxt       = 1'b0;
		case (state)
			ST_IDLE: begin
				seed_cnt_nxt = seed_cnt + 1'b1;
				if (i_start_pulse) begin
					state_nxt     = ST_FAST;
					timer_nxt     = '0;
					step_cnt_nxt  = '0;
					seed_load_nxt = 1'b1;
				end
			end
			ST_FAST, ST_MEDIUM, ST_SLOW: begin
				if (i_stop_pulse) begin
					state_nxt      = ST_STOP;
					last_phase_nxt = state;
				end else if (timer == phase_ticks) begin
					state_nxt    = phase_next;
					timer_nxt    = '0;
					step_cnt_nxt = '0;
				end else begin
					timer_nxt = timer + 1'b1;
					// step_cnt follows the timer modulo the step interval
					if (step_cnt == phase_step - 1'b1) begin
						step_cnt_nxt = '0;
						step_nxt     = 1'b1;
					end else begin
						step_cnt_nxt = step_cnt + 1'b1;
					end
				end
			end
			ST_STOP: begin
				if (i_stop_pulse) begin
					state_nxt = last_phase;
				end
			end
			ST_FINAL: begin
				if (i_start_pulse) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= ST_IDLE;
			last_phase  <= ST_FAST;
			seed_cnt    <= '0;
			timer       <= '0;
			step_cnt    <= '0;
			o_seed_load <= 1'b0;
			o_step      <= 1'b0;
		end else begin
			state       <= state_nxt;
			last_phase  <= last_phase_nxt;
			seed_cnt    <= seed_cnt_nxt;
			timer       <= timer_nxt;
			step_cnt    <= step_cnt_nxt;
			o_seed_load <= seed_load_nxt;
			o_step      <= step_nxt;
		end
	end

	// seed captured at the start press
	always_ff @(posedge i_clk) begin
		if (seed_load_nxt) begin
			o_seed_val <= seed_cnt;
		end
	end

	assign o_state = state;

endmodule

//--- hdl/save_slot.sv
module save_slot (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  dice_pkg::roll_state_t        i_state,
	input  logic                         i_save_pulse,
	input  logic [dice_pkg::VAL_W-1:0]   i_value,
	output logic [dice_pkg::SAVED_W-1:0] o_saved,
	output logic                         o_recall_load,
	output logic [dice_pkg::VAL_W-1:0]   o_recall_val
);

	import dice_pkg::*;

	logic [VAL_W-1:0] slot_val;
	logic slot_full;
	logic store_en;
	logic recall_en;

	// store only once the value has stopped moving
	assign store_en  = i_save_pulse && ((i_state == ST_STOP) || (i_state == ST_FINAL));
	assign recall_en = i_save_pulse && (i_state == ST_IDLE) && slot_full;

	always_ff @(posedge i_clk) begin
		if (store_en) begin
			slot_val <= i_value;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			slot_full     <= 1'b0;
			o_saved       <= SAVED_BLANK;
			o_recall_load <= 1'b0;
		end else begin
			o_recall_load <= recall_en;
			if (store_en) begin
				slot_full <= 1'b1;
			end else if (recall_en) begin
				slot_full <= 1'b0;
			end
			if (i_state != ST_IDLE) begin
				o_saved <= SAVED_BLANK;
			end else if (recall_en) begin
				o_saved <= {1'b0, slot_val};
			end else if (i_save_pulse) begin
				// nothing stored
				o_saved <= SAVED_BLANK;
			end
		end
	end

	assign o_recall_val = slot_val;

endmodule

//--- hdl/seg7_out.sv
module seg7_out (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic [dice_pkg::VAL_W-1:0]   i_value,
	input  logic [dice_pkg::SAVED_W-1:0] i_saved,
	input  dice_pkg::roll_state_t        i_state,
	output logic [dice_pkg::VAL_W-1:0]   o_random_out,
	output logic [dice_pkg::SAVED_W-1:0] o_saved_out,
	output dice_pkg::roll_state_t        o_state_out,
	output logic [dice_pkg::SEG_W-1:0]   o_seg
);

	import dice_pkg::*;

	logic [SEG_W-1:0] seg_nxt;

	// hex digit, bit 6 is segment a
	always_comb begin
		case (i_value)
			4'h0: seg_nxt = 7'b1111110;
			4'h1: seg_nxt = 7'b0110000;
			4'h2: seg_nxt = 7'b1101101;
			4'h3: seg_nxt = 7'b1111001;
			4'h4: seg_nxt = 7'b0110011;
			4'h5: seg_nxt = 7'b1011011;
			4'h6: seg_nxt = 7'b1011111;
			4'h7: seg_nxt = 7'b1110000;
			4'h8: seg_nxt = 7'b1111111;
			4'h9: seg_nxt = 7'b1111011;
			4'ha: seg_nxt = 7'b1110111;
			4'hb: seg_nxt = 7'b0011111;
			4'hc: seg_nxt = 7'b1001110;
			4'hd: seg_nxt = 7'b0111101;
			4'he: seg_nxt = 7'b1001111;
			default: seg_nxt = 7'b1000111;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_saved_out <= SAVED_BLANK;
			o_state_out <= ST_IDLE;
		end else begin
			o_saved_out <= i_saved;
			o_state_out <= i_state;
		end
	end

	// value and its segments stay aligned
	always_ff @(posedge i_clk) begin
		o_random_out <= i_value;
		o_seg        <= seg_nxt;
	end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the dice testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_dice -o tb_dice
./obj_dir/tb_dice

//--- sim/tb_dice.sv
module tb_dice;

	import dice_pkg::*;

	localparam int unsigned FAST_TICKS   = 8;
	localparam int unsigned MEDIUM_TICKS = 12;
	localparam int unsigned SLOW_TICKS   = 16;
	localparam int unsigned FAST_STEP    = 2;
	localparam int unsigned MEDIUM_STEP  = 3;
	localparam int unsigned SLOW_STEP    = 4;
	localparam int unsigned LCG_A        = 11;
	localparam int unsigned LCG_B        = 29;
	localparam int unsigned LCG_SEED     = 9;
	localparam int RST_CYCLES = 16;
	localparam int ROLL_STEPS = FAST_TICKS / FAST_STEP + MEDIUM_TICKS / MEDIUM_STEP
		+ SLOW_TICKS / SLOW_STEP;

	localparam int BTN_NONE  = 0;
	localparam int BTN_START = 1;
	localparam int BTN_STOP  = 2;
	localparam int BTN_SAVE  = 3;
	// extra check done at the end of a row
	localparam int CHK_NONE   = 0;
	localparam int CHK_ROLL   = 1;
	localparam int CHK_STORE  = 2;
	localparam int CHK_RECALL = 3;
	localparam int CHK_BLANK  = 4;

	typedef struct {
		int          button;
		int          hold;
		int          wait_cyc;
		roll_state_t phase;
		int          kind;
	} row_t;

	logic i_clk;
	logic i_rst_n;
	logic i_start;
	logic i_stop;
	logic i_save;
	logic [VAL_W-1:0] o_random_out;
	logic [SAVED_W-1:0] o_saved;
	roll_state_t o_state;
	logic [SEG_W-1:0] o_seg;

	row_t rows[$];
	int total_cycles;
	logic table_ready;
	logic [VAL_W-1:0] stored_val;

	// reference model state
	logic [2:0] m_sync1;
	logic [2:0] m_sync2;
	logic [2:0] m_delay;
	roll_state_t m_state;
	roll_state_t m_last;
	int unsigned m_timer;
	logic [VAL_W-1:0] m_seed_cnt;
	logic [VAL_W-1:0] m_seed_val;
	logic m_seed_load;
	logic m_step;
	logic [VAL_W-1:0] m_value;
	logic [VAL_W-1:0] m_slot;
	logic m_full;
	logic [SAVED_W-1:0] m_saved;
	logic m_recall_load;
	logic [VAL_W-1:0] m_out_value;
	logic [SAVED_W-1:0] m_out_saved;
	roll_state_t m_out_state;

	dice_top #(
		.FAST_TICKS   (FAST_TICKS),
		.MEDIUM_TICKS (MEDIUM_TICKS),
		.SLOW_TICKS   (SLOW_TICKS),
		.FAST_STEP    (FAST_STEP),
		.MEDIUM_STEP  (MEDIUM_STEP),
		.SLOW_STEP    (SLOW_STEP),
		.LCG_A        (LCG_A),
		.LCG_B        (LCG_B),
		.LCG_SEED     (LCG_SEED)
	) dice_top_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_stop       (i_stop),
		.i_save       (i_save),
		.o_random_out (o_random_out),
		.o_saved      (o_saved),
		.o_state      (o_state),
		.o_seg        (o_seg)
	);

	always #2 i_clk = ~i_clk;

	function automatic logic [VAL_W-1:0] lcg_next(input logic [VAL_W-1:0] x);
		int unsigned y;
		y = (LCG_A * int'(x) + LCG_B) % 16;
		return VAL_W'(y);
	endfunction

	function automatic logic [VAL_W-1:0] lcg_repeat(input logic [VAL_W-1:0] x, input int n);
		logic [VAL_W-1:0] v;
		v = x;
		for (int i = 0; i < n; i++) begin
			v = lcg_next(v);
		end
		return v;
	endfunction

	// bit 6 is segment a
	function automatic logic [SEG_W-1:0] seg_of(input logic [VAL_W-1:0] v);
		logic [SEG_W-1:0] table_seg [16];
		table_seg = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
			7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};
		return table_seg[v];
	endfunction

	function automatic void phase_rule(input roll_state_t s, output int unsigned ticks,
		output int unsigned step_int, output roll_state_t nxt);
		case (s)
			ST_MEDIUM: begin
				ticks = MEDIUM_TICKS;
				step_int = MEDIUM_STEP;
				nxt = ST_SLOW;
			end
			ST_SLOW: begin
				ticks = SLOW_TICKS;
				step_int = SLOW_STEP;
				nxt = ST_FINAL;
			end
			default: begin
				ticks = FAST_TICKS;
				step_int = FAST_STEP;
				nxt = ST_MEDIUM;
			end
		endcase
	endfunction

	// model of the board, one update per rising edge
	always @(posedge i_clk) begin
		logic [2:0] pulse;
		logic [VAL_W-1:0] nv;
		logic store;
		logic recall;
		int unsigned ticks;
		int unsigned step_int;
		roll_state_t nxt;
		if (!i_rst_n) begin
			m_sync1 = '0;
			m_sync2 = '0;
			m_delay = '0;
			m_state = ST_IDLE;
			m_last = ST_FAST;
			m_timer = 0;
			m_seed_cnt = '0;
			m_seed_load = 1'b0;
			m_step = 1'b0;
			m_value = VAL_W'(LCG_SEED);
			m_full = 1'b0;
			m_saved = SAVED_BLANK;
			m_recall_load = 1'b0;
			m_out_value = VAL_W'(LCG_SEED);
			m_out_saved = SAVED_BLANK;
			m_out_state = ST_IDLE;
		end else begin
			// bits are start, stop, save
			pulse = m_sync2 & ~m_delay;
			m_out_value = m_value;
			m_out_saved = m_saved;
			m_out_state = m_state;
			nv = m_value;
			if (m_seed_load) begin
				nv = m_seed_val;
			end else if (m_recall_load) begin
				nv = m_slot;
			end else if (m_step) begin
				nv = lcg_next(m_value);
			end
			store = pulse[2] && (m_state == ST_STOP || m_state == ST_FINAL);
			recall = pulse[2] && (m_state == ST_IDLE) && m_full;
			if (m_state != ST_IDLE) begin
				m_saved = SAVED_BLANK;
			end else if (recall) begin
				m_saved = {1'b0, m_slot};
			end else if (pulse[2]) begin
				m_saved = SAVED_BLANK;
			end
			if (store) begin
				m_slot = m_value;
				m_full = 1'b1;
			end else if (recall) begin
				m_full = 1'b0;
			end
			m_recall_load = recall;
			phase_rule(m_state, ticks, step_int, nxt);
			m_seed_load = 1'b0;
			m_step = 1'b0;
			case (m_state)
				ST_IDLE: begin
					if (pulse[0]) begin
						m_seed_val = m_seed_cnt;
						m_seed_load = 1'b1;
						m_timer = 0;
						m_state = ST_FAST;
					end
					m_seed_cnt = m_seed_cnt + 1'b1;
				end
				ST_FAST, ST_MEDIUM, ST_SLOW: begin
					if (pulse[1]) begin
						m_last = m_state;
						m_state = ST_STOP;
					end else if (m_timer == ticks) begin
						m_state = nxt;
						m_timer = 0;
					end else begin
						m_timer = m_timer + 1;
						m_step = (m_timer % step_int) == 0;
					end
				end
				ST_STOP: begin
					if (pulse[1]) begin
						m_state = m_last;
					end
				end
				ST_FINAL: begin
					if (pulse[0]) begin
						m_state = ST_IDLE;
					end
				end
				default: m_state = ST_IDLE;
			endcase
			m_value = nv;
			m_delay = m_sync2;
			m_sync2 = m_sync1;
			m_sync1 = {i_save, i_stop, i_start};
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic add_row(input int button, input int hold, input int wait_cyc,
		input roll_state_t phase, input int kind);
		row_t r;
		r = '{button, hold, wait_cyc, phase, kind};
		rows.push_back(r);
		total_cycles = total_cycles + hold + wait_cyc;
	endtask

	task automatic apply_row(input row_t r);
		i_start = (r.button == BTN_START) && (r.hold > 0);
		i_stop = (r.button == BTN_STOP) && (r.hold > 0);
		i_save = (r.button == BTN_SAVE) && (r.hold > 0);
		repeat (r.hold) @(negedge i_clk);
		i_start = 1'b0;
		i_stop = 1'b0;
		i_save = 1'b0;
		repeat (r.wait_cyc) @(negedge i_clk);
		check("o_state", 32'(o_state), 32'(r.phase));
		check("o_state", 32'(o_state), 32'(m_out_state));
		check("o_random_out", 32'(o_random_out), 32'(m_out_value));
		check("o_saved", 32'(o_saved), 32'(m_out_saved));
		check("o_seg", 32'(o_seg), 32'(seg_of(m_out_value)));
		case (r.kind)
			CHK_ROLL: check("o_random_out", 32'(o_random_out),
				32'(lcg_repeat(m_seed_val, ROLL_STEPS)));
			CHK_STORE: stored_val = m_out_value;
			CHK_RECALL: begin
				check("o_saved", 32'(o_saved), 32'({1'b0, stored_val}));
				check("o_random_out", 32'(o_random_out), 32'(stored_val));
			end
			CHK_BLANK: check("o_saved", 32'(o_saved), 32'(SAVED_BLANK));
			default: ;
		endcase
	endtask

	initial begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_stop = 1'b0;
		i_save = 1'b0;
		table_ready = 1'b0;
		total_cycles = 0;
		void'($urandom(11886));
		add_row(BTN_NONE, 0, 4, ST_IDLE, CHK_NONE);
		// one full roll
		add_row(BTN_START, 1, 6, ST_FAST, CHK_NONE);
		add_row(BTN_NONE, 0, 10, ST_MEDIUM, CHK_NONE);
		add_row(BTN_NONE, 0, 14, ST_SLOW, CHK_NONE);
		add_row(BTN_NONE, 0, 20, ST_FINAL, CHK_ROLL);
		add_row(BTN_START, 1, 3, ST_IDLE, CHK_NONE);
		// freeze in fast, then resume
		add_row(BTN_START, 1, 6, ST_FAST, CHK_NONE);
		add_row(BTN_STOP, 1, 6, ST_STOP, CHK_NONE);
		add_row(BTN_NONE, 0, 10, ST_STOP, CHK_NONE);
		add_row(BTN_STOP, 1, 4, ST_FAST, CHK_NONE);
		add_row(BTN_NONE, 0, 50, ST_FINAL, CHK_ROLL);
		// store, recall, then recall from the empty slot
		add_row(BTN_SAVE, 1, 4, ST_FINAL, CHK_STORE);
		add_row(BTN_START, 1, 4, ST_IDLE, CHK_BLANK);
		add_row(BTN_SAVE, 1, 4, ST_IDLE, CHK_RECALL);
		add_row(BTN_SAVE, 1, 4, ST_IDLE, CHK_BLANK);
		for (int i = 0; i < 4; i++) begin
			add_row(BTN_NONE, 0, int'($urandom_range(40, 1)), ST_IDLE, CHK_NONE);
			add_row(BTN_START, 1, 50, ST_FINAL, CHK_ROLL);
			add_row(BTN_START, 1, 3, ST_IDLE, CHK_NONE);
		end
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (total_cycles + RST_CYCLES + 100) @(posedge i_clk);
		$display("ERRORS FOUND");
		$fatal(1, "timeout, the stimulus table did not finish in time");
	end

endmodule
